// ==== Bender.yml ====
package:
  name: mini_tile

dependencies: {}

sources:
  # Package first, then leaf blocks, then the top level
  - hdl/tile_pkg.sv
  - hdl/tile_lmem.sv
  - hdl/tile_core.sv
  - hdl/tile_noc_out.sv
  - hdl/tile_debug_apb.sv
  - hdl/tile_top.sv

  - target: test
    files:
      - sim/tb_tile_top.sv

// ==== hdl/tile_core.sv ====
`timescale 1ns/1ps
// Multicycle core where FETCH presents the PC and EXEC executes and retires
// Assumes imem returns the word one cycle after the address and holds it while PC holds
// While run_i is low the core idles at PC 0 in FETCH with all registers cleared
module tile_core #(
   parameter int LMEM_WORDS = 64
) (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          run_i,
   output logic [$clog2(LMEM_WORDS)-1:0] imem_addr_o,
   input  tile_pkg::insn_t               imem_rdata_i,
   output logic                          send_valid_o,
   output tile_pkg::word_t               send_flit_o,
   output logic                          send_last_o,
   input  logic                          send_ready_i,
   output logic                          halted_o,
   output logic                          trace_valid_o,
   output logic [$clog2(LMEM_WORDS)-1:0] trace_pc_o,
   output tile_pkg::insn_t               trace_insn_o,
   output logic                          trace_wben_o,
   output tile_pkg::reg_idx_t            trace_wbreg_o,
   output tile_pkg::word_t               trace_wbdata_o
);

   localparam int PC_W = $clog2(LMEM_WORDS);

   tile_pkg::core_state_e state_q;
   tile_pkg::core_state_e state_d;
   logic [PC_W-1:0]       pc_q;
   tile_pkg::word_t       regs_q [8];

   // Decoded fields
   tile_pkg::opcode_e  opcode;
   tile_pkg::reg_idx_t rd;
   tile_pkg::reg_idx_t rs;
   tile_pkg::word_t    imm;
   tile_pkg::word_t    rd_val;
   tile_pkg::word_t    rs_val;
   tile_pkg::word_t    wb_data;
   logic               wb_en;
   logic               in_exec;
   logic               is_send;
   logic               retire;

   assign opcode = tile_pkg::opcode_e'(imem_rdata_i[15:12]);
   assign rd     = imem_rdata_i[11:9];
   assign rs     = imem_rdata_i[8:6];
   // Immediate is zero-extended
   assign imm    = {8'h00, imem_rdata_i[7:0]};
   assign rd_val = regs_q[rd];
   assign rs_val = regs_q[rs];

   // SEND_WAIT only ever holds a SEND whose word stays on imem_rdata_i
   assign in_exec = run_i && (state_q == tile_pkg::EXEC || state_q == tile_pkg::SEND_WAIT);
   assign is_send = (opcode == tile_pkg::OP_SEND);
   // Retire unless a SEND is blocked by the buffer
   assign retire  = in_exec && (!is_send || send_ready_i);

   // Writeback result wraps mod 2^16
   always_comb begin
      wb_en   = 1'b0;
      wb_data = rd_val;
      case (opcode)
         tile_pkg::OP_LI: begin
            wb_en   = 1'b1;
            wb_data = imm;
         end
         tile_pkg::OP_ADDI: begin
            wb_en   = 1'b1;
            wb_data = rd_val + imm;
         end
         tile_pkg::OP_ADD: begin
            wb_en   = 1'b1;
            wb_data = rd_val + rs_val;
         end
         // NOP, SEND, HALT and unknown opcodes write nothing
         default: begin
            wb_en = 1'b0;
         end
      endcase
   end

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         tile_pkg::FETCH: state_d = tile_pkg::EXEC;
         tile_pkg::EXEC, tile_pkg::SEND_WAIT: begin
            if (!retire) begin
               state_d = tile_pkg::SEND_WAIT;
            end else if (opcode == tile_pkg::OP_HALT) begin
               state_d = tile_pkg::HALTED;
            end else begin
               state_d = tile_pkg::FETCH;
            end
         end
         // Only a run clear leaves HALTED
         default: state_d = tile_pkg::HALTED;
      endcase
   end

   // State, PC and register file
   always_ff @(posedge clk_i) begin
      if (reset_i || !run_i) begin
         state_q <= tile_pkg::FETCH;
         pc_q    <= '0;
         for (int i = 0; i < 8; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         state_q <= state_d;
         // PC wraps at the memory depth
         if (retire && opcode != tile_pkg::OP_HALT) begin
            pc_q <= pc_q + 1'b1;
         end
         if (retire && wb_en) begin
            regs_q[rd] <= wb_data;
         end
      end
   end

   // Fetch address held through EXEC and SEND_WAIT
   assign imem_addr_o = pc_q;

   // Send request toward the NoC buffer
   assign send_valid_o = in_exec && is_send;
   assign send_flit_o  = rs_val;
   assign send_last_o  = imem_rdata_i[0];

   assign halted_o = (state_q == tile_pkg::HALTED);

   // Writeback trace, one pulse per retired instruction
   assign trace_valid_o  = retire;
   assign trace_pc_o     = pc_q;
   assign trace_insn_o   = imem_rdata_i;
   assign trace_wben_o   = wb_en;
   assign trace_wbreg_o  = rd;
   assign trace_wbdata_o = wb_data;

   // A blocked SEND stays in SEND_WAIT with its request unchanged
   a_send_held: assert property (
      @(posedge clk_i) disable iff (reset_i)
      send_valid_o && !send_ready_i |=>
         !run_i || (state_q == tile_pkg::SEND_WAIT && send_valid_o &&
                    $stable(send_flit_o) && $stable(send_last_o))
   ) else $error("blocked send request dropped or changed");

   // HALTED holds with no trace pulse until run clears
   a_halt_quiet: assert property (
      @(posedge clk_i) disable iff (reset_i)
      halted_o && run_i |=> halted_o && !trace_valid_o
   ) else $error("trace pulse or exit from HALTED while run is set");

endmodule

// ==== hdl/tile_debug_apb.sv ====
`timescale 1ns/1ps
// APB slave for program load and run control, pready_o is tied high
// Program writes are refused with pslverr while run is set, program reads give 0
// r3 shadow and retired counter are cleared whenever run is low
module tile_debug_apb #(
   parameter int LMEM_WORDS = 64
) (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic [11:0]          paddr_i,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  logic [31:0]          pwdata_i,
   output logic [31:0]          prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output logic                 lmem_we_o,
   output tile_pkg::lmem_addr_t lmem_waddr_o,
   output tile_pkg::insn_t      lmem_wdata_o,
   output logic                 run_o,
   input  logic                 halted_i,
   input  logic                 trace_valid_i,
   input  logic                 trace_wben_i,
   input  tile_pkg::reg_idx_t   trace_wbreg_i,
   input  tile_pkg::word_t      trace_wbdata_i
);

   // Size of the program window in bytes
   localparam logic [11:0] PROG_BYTES = 12'(LMEM_WORDS * 4);

   logic            access;
   logic [11:0]     prog_off;
   logic            prog_hit;
   logic            ctrl_hit;
   logic            status_hit;
   logic            r3_hit;
   logic            retired_hit;
   logic            mapped;
   logic            run_q;
   tile_pkg::word_t r3_q;
   logic [31:0]     retired_q;

   // Access phase of a transfer
   assign access = psel_i && penable_i;

   // Address decode
   assign prog_off    = paddr_i - tile_pkg::PROG_BASE;
   assign prog_hit    = (prog_off < PROG_BYTES) && (paddr_i[1:0] == 2'b00);
   assign ctrl_hit    = (paddr_i == tile_pkg::REG_CTRL);
   assign status_hit  = (paddr_i == tile_pkg::REG_STATUS);
   assign r3_hit      = (paddr_i == tile_pkg::REG_R3);
   assign retired_hit = (paddr_i == tile_pkg::REG_RETIRED);
   assign mapped      = prog_hit || ctrl_hit || status_hit || r3_hit || retired_hit;

   // No wait states
   assign pready_o  = 1'b1;
   assign pslverr_o = access && (!mapped || (prog_hit && pwrite_i && run_q));

   // Program load only while the core is stopped
   assign lmem_we_o    = access && pwrite_i && prog_hit && !run_q;
   assign lmem_waddr_o = prog_off[7:2];
   assign lmem_wdata_o = pwdata_i[15:0];

   // Read mux, program window and unmapped read as 0
   always_comb begin
      prdata_o = '0;
      if (ctrl_hit) begin
         prdata_o = {31'b0, run_q};
      end else if (status_hit) begin
         prdata_o = {31'b0, halted_i};
      end else if (r3_hit) begin
         prdata_o = {16'b0, r3_q};
      end else if (retired_hit) begin
         prdata_o = retired_q;
      end
   end

   // Run control bit
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         run_q <= 1'b0;
      end else if (access && pwrite_i && ctrl_hit) begin
         run_q <= pwdata_i[0];
      end
   end

   assign run_o = run_q;

   // Shadow r3 and count retires, one cycle behind the trace
   always_ff @(posedge clk_i) begin
      if (reset_i || !run_q) begin
         r3_q      <= '0;
         retired_q <= '0;
      end else if (trace_valid_i) begin
         retired_q <= retired_q + 32'd1;
         if (trace_wben_i && trace_wbreg_i == 3'd3) begin
            r3_q <= trace_wbdata_i;
         end
      end
   end

endmodule

// ==== hdl/tile_lmem.sv ====
`timescale 1ns/1ps
// Local instruction memory, LMEM_WORDS deep (power of two, at most 64)
// Read data appears one cycle after the read address, no reset on contents
// Write port indexes the full 64-word program window, caller keeps it in range
module tile_lmem #(
   parameter int LMEM_WORDS = 64
) (
   input  logic                          clk_i,
   input  logic                          we_i,
   input  tile_pkg::lmem_addr_t          waddr_i,
   input  tile_pkg::insn_t               wdata_i,
   input  logic [$clog2(LMEM_WORDS)-1:0] raddr_i,
   output tile_pkg::insn_t               rdata_o
);

   localparam int AW = $clog2(LMEM_WORDS);

   // Storage array
   tile_pkg::insn_t mem_q [LMEM_WORDS];

   // Write from the debug block
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem_q[waddr_i[AW-1:0]] <= wdata_i;
      end
   end

   // Registered read for the core
   // Same-address write returns the old word
   always_ff @(posedge clk_i) begin
      rdata_o <= mem_q[raddr_i];
   end

   // Debug block must filter program writes beyond the memory depth
   a_waddr_in_range: assert property (
      @(posedge clk_i) we_i |-> (waddr_i < LMEM_WORDS)
   ) else $error("lmem write to word %0d beyond depth %0d", waddr_i, LMEM_WORDS);

endmodule

// ==== hdl/tile_noc_out.sv ====
`timescale 1ns/1ps
// Two-entry flit FIFO between core send requests and the NoC output
// At least one cycle from push to noc_out_valid_o, flits leave in order
module tile_noc_out (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            send_valid_i,
   input  tile_pkg::word_t send_flit_i,
   input  logic            send_last_i,
   output logic            send_ready_o,
   output tile_pkg::word_t noc_out_flit_o,
   output logic            noc_out_last_o,
   output logic            noc_out_valid_o,
   input  logic            noc_out_ready_i
);

   // Payload storage, no reset
   tile_pkg::word_t flit_q [2];
   logic            last_q [2];

   // Control state
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] count_q;
   logic       push;
   logic       pop;

   // Full blocks the core, independent of a pop this cycle
   assign send_ready_o    = (count_q != 2'd2);
   assign noc_out_valid_o = (count_q != 2'd0);
   assign push            = send_valid_i && send_ready_o;
   assign pop             = noc_out_valid_o && noc_out_ready_i;

   // Head entry
   assign noc_out_flit_o = flit_q[rd_ptr_q];
   assign noc_out_last_o = last_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         flit_q[wr_ptr_q] <= send_flit_i;
         last_q[wr_ptr_q] <= send_last_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         // Push and pop together keep the level
         count_q <= count_q + {1'b0, push} - {1'b0, pop};
      end
   end

   // Stalled flit must hold until taken
   a_out_stable: assert property (
      @(posedge clk_i) disable iff (reset_i)
      noc_out_valid_o && !noc_out_ready_i |=>
         noc_out_valid_o && $stable(noc_out_flit_o) && $stable(noc_out_last_o)
   ) else $error("NoC output changed while stalled");

endmodule

// ==== hdl/tile_pkg.sv ====
// Types, opcodes and APB register map shared by all tile blocks
// Instruction fields: opcode [15:12], rd [11:9], rs [8:6], imm [7:0]
// Opcodes outside opcode_e decode as NOP in the core
package tile_pkg;

   // Datapath widths
   typedef logic [15:0] insn_t;
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // Word index into the program window, sized for the largest memory (64 words)
   typedef logic [5:0]  lmem_addr_t;

   // Opcode field
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_LI   = 4'h1,
      OP_ADDI = 4'h2,
      OP_ADD  = 4'h3,
      OP_SEND = 4'h4,
      OP_HALT = 4'h5
   } opcode_e;

   // Core FSM
   typedef enum logic [1:0] {
      FETCH     = 2'd0,
      EXEC      = 2'd1,
      SEND_WAIT = 2'd2,
      HALTED    = 2'd3
   } core_state_e;

   // APB byte addresses
   // Program words from PROG_BASE, one word per 4 bytes
   localparam logic [11:0] PROG_BASE   = 12'h000;
   localparam logic [11:0] REG_CTRL    = 12'h100;
   localparam logic [11:0] REG_STATUS  = 12'h104;
   localparam logic [11:0] REG_R3      = 12'h108;
   localparam logic [11:0] REG_RETIRED = 12'h10C;

endpackage

// ==== hdl/tile_top.sv ====
`timescale 1ns/1ps
// Single-core tile: local memory, core, NoC output buffer and APB debug block
// LMEM_WORDS must be a power of two between 2 and 64
// No incoming NoC channel, the core only sends
module tile_top #(
   parameter int LMEM_WORDS = 64
) (
   input  logic                          clk_i,
   input  logic                          reset_i,
   // APB slave
   input  logic [11:0]                   paddr_i,
   input  logic                          psel_i,
   input  logic                          penable_i,
   input  logic                          pwrite_i,
   input  logic [31:0]                   pwdata_i,
   output logic [31:0]                   prdata_o,
   output logic                          pready_o,
   output logic                          pslverr_o,
   // NoC output
   output tile_pkg::word_t               noc_out_flit_o,
   output logic                          noc_out_last_o,
   output logic                          noc_out_valid_o,
   input  logic                          noc_out_ready_i,
   // Writeback trace
   output logic                          trace_valid_o,
   output logic [$clog2(LMEM_WORDS)-1:0] trace_pc_o,
   output tile_pkg::insn_t               trace_insn_o,
   output logic                          trace_wben_o,
   output tile_pkg::reg_idx_t            trace_wbreg_o,
   output tile_pkg::word_t               trace_wbdata_o
);

   localparam int PC_W = $clog2(LMEM_WORDS);

   // Debug block to memory
   logic                 lmem_we;
   tile_pkg::lmem_addr_t lmem_waddr;
   tile_pkg::insn_t      lmem_wdata;

   // Core to memory
   logic [PC_W-1:0]      imem_addr;
   tile_pkg::insn_t      imem_rdata;

   // Core control and status
   logic                 cpu_run;
   logic                 halted;

   // Core to NoC buffer
   logic                 send_valid;
   tile_pkg::word_t      send_flit;
   logic                 send_last;
   logic                 send_ready;

   tile_lmem #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_lmem (
      .clk_i   (clk_i),
      .we_i    (lmem_we),
      .waddr_i (lmem_waddr),
      .wdata_i (lmem_wdata),
      .raddr_i (imem_addr),
      .rdata_o (imem_rdata)
   );

   tile_core #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_core (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .run_i          (cpu_run),
      .imem_addr_o    (imem_addr),
      .imem_rdata_i   (imem_rdata),
      .send_valid_o   (send_valid),
      .send_flit_o    (send_flit),
      .send_last_o    (send_last),
      .send_ready_i   (send_ready),
      .halted_o       (halted),
      .trace_valid_o  (trace_valid_o),
      .trace_pc_o     (trace_pc_o),
      .trace_insn_o   (trace_insn_o),
      .trace_wben_o   (trace_wben_o),
      .trace_wbreg_o  (trace_wbreg_o),
      .trace_wbdata_o (trace_wbdata_o)
   );

   tile_noc_out u_noc_out (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .send_valid_i    (send_valid),
      .send_flit_i     (send_flit),
      .send_last_i     (send_last),
      .send_ready_o    (send_ready),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_last_o  (noc_out_last_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

   // Trace ports also feed the r3 shadow and retire counter
   tile_debug_apb #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_debug (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .paddr_i        (paddr_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .lmem_we_o      (lmem_we),
      .lmem_waddr_o   (lmem_waddr),
      .lmem_wdata_o   (lmem_wdata),
      .run_o          (cpu_run),
      .halted_i       (halted),
      .trace_valid_i  (trace_valid_o),
      .trace_wben_i   (trace_wben_o),
      .trace_wbreg_i  (trace_wbreg_o),
      .trace_wbdata_i (trace_wbdata_o)
   );

endmodule

// ==== mini_tile.f ====
hdl/tile_pkg.sv
hdl/tile_lmem.sv
hdl/tile_core.sv
hdl/tile_noc_out.sv
hdl/tile_debug_apb.sv
hdl/tile_top.sv
sim/tb_tile_top.sv

// ==== sim/tb_tile_top.sv ====
`timescale 1ns/1ps
// System testbench for tile_top with programs from a table applied in a loop
// Expected r3, retired count, flits and trace come from an ISA model run on the table
// Every program must end in HALT within its 16 words
module tb_tile_top;

   localparam int LMEM_WORDS  = 64;
   localparam int NUM_TESTS   = 6;
   localparam int MODE_PLAIN   = 0;
   localparam int MODE_STALL   = 1;
   localparam int MODE_RESTART = 2;
   localparam int MODE_APBERR  = 3;

   logic clk;
   logic reset;
   logic [11:0] paddr;
   logic psel;
   logic penable;
   logic pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;
   logic [15:0] noc_flit;
   logic noc_last;
   logic noc_valid;
   logic noc_ready;
   logic trace_valid;
   logic [$clog2(LMEM_WORDS)-1:0] trace_pc;
   logic [15:0] trace_insn;
   logic trace_wben;
   logic [2:0] trace_wbreg;
   logic [15:0] trace_wbdata;

   // Program table
   string prog_name [NUM_TESTS];
   logic [15:0] prog_mem [NUM_TESTS][16];
   int prog_len [NUM_TESTS];
   int prog_mode [NUM_TESTS];

   // Model results and observed traffic with flits packed as {last, payload}
   logic [15:0] exp_r3;
   int exp_retired;
   logic [15:0] exp_wbdata [16];
   logic [16:0] exp_flits [$];
   logic [16:0] got_flits [$];
   logic [31:0] trace_pcs [$];
   logic [15:0] trace_insns [$];
   logic trace_wbens [$];
   logic [2:0] trace_wbregs [$];
   logic [15:0] trace_wbdatas [$];

   int errors;
   int checks;
   int test_errs;
   int cycles;
   int cycle_limit;
   logic hold_low;
   logic [31:0] rnd;

   tile_top #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_dut (
      .clk_i           (clk),
      .reset_i         (reset),
      .paddr_i         (paddr),
      .psel_i          (psel),
      .penable_i       (penable),
      .pwrite_i        (pwrite),
      .pwdata_i        (pwdata),
      .prdata_o        (prdata),
      .pready_o        (pready),
      .pslverr_o       (pslverr),
      .noc_out_flit_o  (noc_flit),
      .noc_out_last_o  (noc_last),
      .noc_out_valid_o (noc_valid),
      .noc_out_ready_i (noc_ready),
      .trace_valid_o   (trace_valid),
      .trace_pc_o      (trace_pc),
      .trace_insn_o    (trace_insn),
      .trace_wben_o    (trace_wben),
      .trace_wbreg_o   (trace_wbreg),
      .trace_wbdata_o  (trace_wbdata)
   );

   always #50 clk = ~clk;

   // Random ready forced low during a stall window
   always @(posedge clk) begin
      #5;
      rnd = $urandom;
      noc_ready = !hold_low && rnd[0];
   end

   // Sample mid-cycle where outputs are stable
   always @(negedge clk) begin
      if (!reset && trace_valid) begin
         trace_pcs.push_back(trace_pc);
         trace_insns.push_back(trace_insn);
         trace_wbens.push_back(trace_wben);
         trace_wbregs.push_back(trace_wbreg);
         trace_wbdatas.push_back(trace_wbdata);
      end
      if (!reset && noc_valid && noc_ready) begin
         got_flits.push_back({noc_last, noc_flit});
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles: the core never halted", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic logic [15:0] enc_imm(logic [3:0] op, logic [2:0] rd, logic [7:0] imm);
      return {op, rd, 1'b0, imm};
   endfunction

   function automatic logic [15:0] enc_reg(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                           logic last);
      return {op, rd, rs, 5'b0, last};
   endfunction

   // Writes back only for LI, ADDI and ADD
   function automatic logic writes_reg(logic [15:0] w);
      return w[15:12] == tile_pkg::OP_LI || w[15:12] == tile_pkg::OP_ADDI ||
             w[15:12] == tile_pkg::OP_ADD;
   endfunction

   task automatic append_insn(input int t, input logic [15:0] w);
      prog_mem[t][prog_len[t]] = w;
      prog_len[t]++;
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
         errors++;
         test_errs++;
      end
   endtask

   // One APB transfer with setup then access phase
   task automatic apb_transfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      @(posedge clk);
      #5;
      psel = 1'b1;
      penable = 1'b0;
      pwrite = write;
      paddr = addr;
      pwdata = wdata;
      @(posedge clk);
      #5;
      penable = 1'b1;
      @(negedge clk);
      while (!pready) @(negedge clk);
      rdata = prdata;
      err = pslverr;
      @(posedge clk);
      #5;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   // ISA reference model running straight line until HALT
   task automatic run_model(input int t);
      logic [15:0] regs [8];
      logic [15:0] w;
      logic [2:0] rd;
      logic [2:0] rs;
      logic done;
      int pc;
      for (int r = 0; r < 8; r++) regs[r] = '0;
      exp_flits.delete();
      exp_retired = 0;
      done = 1'b0;
      pc = 0;
      while (!done && pc < prog_len[t]) begin
         w = prog_mem[t][pc];
         rd = w[11:9];
         rs = w[8:6];
         case (w[15:12])
            tile_pkg::OP_LI:   regs[rd] = {8'h00, w[7:0]};
            tile_pkg::OP_ADDI: regs[rd] = regs[rd] + {8'h00, w[7:0]};
            tile_pkg::OP_ADD:  regs[rd] = regs[rd] + regs[rs];
            tile_pkg::OP_SEND: exp_flits.push_back({w[0], regs[rs]});
            tile_pkg::OP_HALT: done = 1'b1;
            default: ;
         endcase
         if (writes_reg(w)) begin
            exp_wbdata[pc] = regs[rd];
         end
         exp_retired++;
         pc++;
      end
      exp_r3 = regs[3];
   endtask

   // Start a throwaway program and stop it part way
   task automatic abort_run(input string name);
      logic [31:0] rdata;
      logic err;
      for (int i = 0; i < 8; i++) begin
         apb_transfer(1'b1, 12'(tile_pkg::PROG_BASE + 4 * i),
                      (i == 0) ? enc_imm(tile_pkg::OP_LI, 3'd3, 8'h55) :
                      (i == 7) ? {tile_pkg::OP_HALT, 12'h000} :
                      enc_imm(tile_pkg::OP_ADDI, 3'd3, 8'h01), rdata, err);
      end
      apb_transfer(1'b1, tile_pkg::REG_CTRL, 32'd1, rdata, err);
      repeat (8) @(posedge clk);
      apb_transfer(1'b1, tile_pkg::REG_CTRL, 32'd0, rdata, err);
      // Stopped core drops all state
      apb_transfer(1'b0, tile_pkg::REG_R3, 32'd0, rdata, err);
      check_value(name, "r3 after stop", 32'd0, rdata);
      apb_transfer(1'b0, tile_pkg::REG_RETIRED, 32'd0, rdata, err);
      check_value(name, "retired after stop", 32'd0, rdata);
   endtask

   task automatic run_test(input int t);
      string name;
      logic [31:0] rdata;
      logic err;
      name = prog_name[t];
      test_errs = 0;
      apb_transfer(1'b1, tile_pkg::REG_CTRL, 32'd0, rdata, err);
      if (prog_mode[t] == MODE_RESTART) abort_run(name);
      if (prog_mode[t] == MODE_APBERR) begin
         apb_transfer(1'b0, 12'h200, 32'd0, rdata, err);
         check_value(name, "unmapped pslverr", 32'd1, err);
      end
      for (int i = 0; i < prog_len[t]; i++) begin
         apb_transfer(1'b1, 12'(tile_pkg::PROG_BASE + 4 * i), prog_mem[t][i], rdata, err);
         check_value(name, "load pslverr", 32'd0, err);
      end
      run_model(t);
      got_flits.delete();
      trace_pcs.delete();
      trace_insns.delete();
      trace_wbens.delete();
      trace_wbregs.delete();
      trace_wbdatas.delete();
      hold_low = (prog_mode[t] == MODE_STALL);
      apb_transfer(1'b1, tile_pkg::REG_CTRL, 32'd1, rdata, err);
      if (prog_mode[t] == MODE_APBERR) begin
         // Try to replace the not yet fetched NOP at word 3 with LI r3
         apb_transfer(1'b1, 12'(tile_pkg::PROG_BASE + 12),
                      {16'h0, enc_imm(tile_pkg::OP_LI, 3'd3, 8'hEE)}, rdata, err);
         check_value(name, "running write pslverr", 32'd1, err);
      end
      if (prog_mode[t] == MODE_STALL) begin
         repeat (30) @(posedge clk);
         apb_transfer(1'b0, tile_pkg::REG_STATUS, 32'd0, rdata, err);
         check_value(name, "halted under stall", 32'd0, rdata[0]);
         hold_low = 1'b0;
      end
      // Poll until the core reports halted
      rdata = '0;
      while (!rdata[0]) apb_transfer(1'b0, tile_pkg::REG_STATUS, 32'd0, rdata, err);
      apb_transfer(1'b0, tile_pkg::REG_R3, 32'd0, rdata, err);
      check_value(name, "r3", {16'h0, exp_r3}, rdata);
      apb_transfer(1'b0, tile_pkg::REG_RETIRED, 32'd0, rdata, err);
      check_value(name, "retired", exp_retired, rdata);
      // Drain the buffer
      @(negedge clk);
      while (noc_valid) @(negedge clk);
      check_value(name, "flit count", exp_flits.size(), got_flits.size());
      for (int i = 0; i < got_flits.size() && i < exp_flits.size(); i++) begin
         check_value(name, "flit", exp_flits[i], got_flits[i]);
      end
      check_value(name, "trace count", exp_retired, trace_pcs.size());
      for (int i = 0; i < trace_pcs.size() && i < exp_retired; i++) begin
         check_value(name, "trace pc", i % LMEM_WORDS, trace_pcs[i]);
         check_value(name, "trace insn", prog_mem[t][i], trace_insns[i]);
         check_value(name, "trace wben", writes_reg(prog_mem[t][i]), trace_wbens[i]);
         if (writes_reg(prog_mem[t][i])) begin
            check_value(name, "trace wbreg", prog_mem[t][i][11:9], trace_wbregs[i]);
            check_value(name, "trace wbdata", exp_wbdata[i], trace_wbdatas[i]);
         end
      end
      $display("test %s: %s", name, (test_errs == 0) ? "pass" : "fail");
   endtask

   task automatic build_table;
      for (int t = 0; t < NUM_TESTS; t++) prog_len[t] = 0;
      prog_name[0] = "arith_basic";
      prog_mode[0] = MODE_PLAIN;
      append_insn(0, enc_imm(tile_pkg::OP_LI, 3'd3, 8'h05));
      append_insn(0, enc_imm(tile_pkg::OP_ADDI, 3'd3, 8'h07));
      append_insn(0, enc_imm(tile_pkg::OP_LI, 3'd4, 8'h20));
      append_insn(0, enc_reg(tile_pkg::OP_ADD, 3'd3, 3'd4, 1'b0));
      append_insn(0, 16'h0000);
      append_insn(0, {tile_pkg::OP_HALT, 12'h000});
      // r2 doubles up to 16'hFF00 and r3 then crosses 16'hFFFF
      prog_name[1] = "arith_wrap";
      prog_mode[1] = MODE_PLAIN;
      append_insn(1, enc_imm(tile_pkg::OP_LI, 3'd2, 8'hFF));
      for (int i = 0; i < 8; i++) append_insn(1, enc_reg(tile_pkg::OP_ADD, 3'd2, 3'd2, 1'b0));
      append_insn(1, enc_imm(tile_pkg::OP_LI, 3'd3, 8'hFF));
      append_insn(1, enc_reg(tile_pkg::OP_ADD, 3'd3, 3'd2, 1'b0));
      append_insn(1, enc_imm(tile_pkg::OP_ADDI, 3'd3, 8'h12));
      append_insn(1, {tile_pkg::OP_HALT, 12'h000});
      prog_name[2] = "send_seq";
      prog_mode[2] = MODE_PLAIN;
      append_insn(2, enc_imm(tile_pkg::OP_LI, 3'd1, 8'h11));
      append_insn(2, enc_imm(tile_pkg::OP_LI, 3'd2, 8'h22));
      append_insn(2, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd1, 1'b0));
      append_insn(2, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd2, 1'b1));
      append_insn(2, enc_imm(tile_pkg::OP_ADDI, 3'd1, 8'h01));
      append_insn(2, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd1, 1'b0));
      append_insn(2, enc_reg(tile_pkg::OP_ADD, 3'd3, 3'd1, 1'b0));
      append_insn(2, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd3, 1'b1));
      append_insn(2, {tile_pkg::OP_HALT, 12'h000});
      // Five sends against a blocked output
      prog_name[3] = "stall_five";
      prog_mode[3] = MODE_STALL;
      append_insn(3, enc_imm(tile_pkg::OP_LI, 3'd1, 8'hA1));
      append_insn(3, enc_imm(tile_pkg::OP_LI, 3'd2, 8'hB2));
      for (int i = 0; i < 5; i++) begin
         append_insn(3, enc_reg(tile_pkg::OP_SEND, 3'd0, (i % 2) ? 3'd2 : 3'd1, i == 4));
      end
      append_insn(3, enc_imm(tile_pkg::OP_LI, 3'd3, 8'h09));
      append_insn(3, {tile_pkg::OP_HALT, 12'h000});
      // ADDI first so a stale r3 from the aborted run would show
      prog_name[4] = "restart";
      prog_mode[4] = MODE_RESTART;
      append_insn(4, enc_imm(tile_pkg::OP_ADDI, 3'd3, 8'h33));
      append_insn(4, enc_imm(tile_pkg::OP_ADDI, 3'd3, 8'h01));
      append_insn(4, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd3, 1'b1));
      append_insn(4, {tile_pkg::OP_HALT, 12'h000});
      // Opcode 4'hF decodes as NOP
      prog_name[5] = "apb_errors";
      prog_mode[5] = MODE_APBERR;
      append_insn(5, enc_imm(tile_pkg::OP_LI, 3'd3, 8'h42));
      append_insn(5, enc_reg(tile_pkg::OP_ADD, 3'd3, 3'd3, 1'b0));
      append_insn(5, enc_reg(tile_pkg::OP_SEND, 3'd0, 3'd3, 1'b1));
      append_insn(5, 16'hF000);
      append_insn(5, {tile_pkg::OP_HALT, 12'h000});
   endtask

   initial begin
      int total;
      clk = 1'b0;
      reset = 1'b1;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      noc_ready = 1'b0;
      hold_low = 1'b0;
      errors = 0;
      checks = 0;
      cycles = 0;
      rnd = $urandom(32'h8d76);
      build_table();
      total = 0;
      for (int t = 0; t < NUM_TESTS; t++) total += prog_len[t];
      cycle_limit = 40 * total + 2000;
      repeat (16) @(posedge clk);
      #5;
      reset = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++) run_test(t);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
